// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := ftx_tb
FLIST := ftx_top.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

// ==== ftx_top.f ====
+incdir+hdl
hdl/ftx_pkg.sv
hdl/seg_rd_if.sv
hdl/slot_counter.sv
hdl/frame_sequencer.sv
hdl/segment_store.sv
hdl/lane_mux.sv
hdl/ftx_top.sv
verif/ftx_tb.sv

// ==== hdl/frame_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ftx_config.svh"

module frame_sequencer (
    input  wire logic          tx_clk,
    input  wire logic          rst_n_i,
    input  wire logic          ready_i,       // link up, low aborts
    input  wire logic          send_i,        // send request strobe
    input  ftx_pkg::slot_t     slot_i,        // current slot
    seg_rd_if.sequencer        rd,            // segment store access
    output ftx_pkg::byte_t     frame_byte_o,  // data lane byte
    output logic               frame_is_k_o,  // data lane K flag
    output logic               busy_o         // frame pending or in flight
);

    ftx_pkg::frame_state_e state_q;
    ftx_pkg::frame_state_e state_d;
    ftx_pkg::seg_idx_t     data_idx_q;  // next data byte
    logic                  odd_slot;    // frame bytes only on odd slots
    logic                  last_data;

    assign odd_slot  = slot_i[0];
    assign last_data = (data_idx_q == ftx_pkg::seg_idx_t'(`FTX_SEG_BYTES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ftx_pkg::IDLE:      if (send_i) state_d = ftx_pkg::WAIT_SLOT;  // latch request
            ftx_pkg::WAIT_SLOT: if (!odd_slot) state_d = ftx_pkg::START;   // next slot is odd
            ftx_pkg::START:     if (odd_slot) state_d = ftx_pkg::ADDR;
            ftx_pkg::ADDR:      if (odd_slot) state_d = ftx_pkg::DATA;
            ftx_pkg::DATA:      if (odd_slot && last_data) state_d = ftx_pkg::STOP;
            ftx_pkg::STOP:      if (odd_slot) state_d = ftx_pkg::CSUM_HI;
            ftx_pkg::CSUM_HI:   if (odd_slot) state_d = ftx_pkg::CSUM_LO;
            ftx_pkg::CSUM_LO:   if (odd_slot) state_d = ftx_pkg::IDLE;
            default:            state_d = ftx_pkg::IDLE;
        endcase
        if (!ready_i) begin
            state_d = ftx_pkg::IDLE;  // link lost, drop frame
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ftx_pkg::IDLE;
            data_idx_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q != ftx_pkg::DATA) begin
                data_idx_q <= '0;                                 // rewind per frame
            end else if (odd_slot) begin
                data_idx_q <= data_idx_q + ftx_pkg::seg_idx_t'(1);
            end
        end
    end

    assign busy_o  = (state_q != ftx_pkg::IDLE);
    assign rd.lock = busy_o;                                      // freezes the store
    assign rd.acc  = odd_slot && ((state_q == ftx_pkg::ADDR) || (state_q == ftx_pkg::DATA));

    always_comb begin
        rd.rd_sel    = '0;  // address by default
        frame_byte_o = '0;
        frame_is_k_o = 1'b0;
        if (state_q == ftx_pkg::DATA) begin
            rd.rd_sel = ftx_pkg::seg_sel_t'(data_idx_q) + ftx_pkg::seg_sel_t'(1);
        end
        if (odd_slot) begin  // even slots belong to the distributed bus
            case (state_q)
                ftx_pkg::START: begin
                    frame_byte_o = ftx_pkg::byte_t'(ftx_pkg::CODE_START);
                    frame_is_k_o = 1'b1;
                end
                ftx_pkg::ADDR,
                ftx_pkg::DATA:    frame_byte_o = rd.rd_byte;
                ftx_pkg::STOP: begin
                    frame_byte_o = ftx_pkg::byte_t'(ftx_pkg::CODE_STOP);
                    frame_is_k_o = 1'b1;
                end
                ftx_pkg::CSUM_HI: frame_byte_o = rd.csum[15:8];  // high byte first
                ftx_pkg::CSUM_LO: frame_byte_o = rd.csum[7:0];
                default:          frame_byte_o = '0;
            endcase
        end
    end

    // start code always lands on an odd slot
    a_start_odd_slot : assert property (@(posedge tx_clk) disable iff (!rst_n_i)
        state_q == ftx_pkg::START |-> odd_slot);

    // checksum bytes never on back to back slots
    a_acc_spaced : assert property (@(posedge tx_clk) disable iff (!rst_n_i)
        rd.acc |=> !rd.acc);

endmodule

`default_nettype wire

// ==== hdl/ftx_config.svh ====
`ifndef FTX_CONFIG_SVH
`define FTX_CONFIG_SVH

// segmented data frame
`define FTX_SEG_BYTES      16   // data bytes per segment

// symbol slot ring
`define FTX_SLOT_COUNT     64   // slots before wrap

// event lane cadence, in slots
`define FTX_COMMA_PERIOD   4    // K28.5 every 4th slot
`define FTX_BEACON_PERIOD  7    // beacon on remaining 7th slots

`endif

// ==== hdl/ftx_pkg.sv ====
`default_nettype none

`include "ftx_config.svh"

package ftx_pkg;

    typedef logic [7:0]  byte_t;    // one lane byte
    typedef logic [15:0] word_t;    // {data lane, event lane}
    typedef logic [1:0]  kflags_t;  // {data k, event k}
    typedef logic [15:0] csum_t;    // frame checksum

    typedef logic [$clog2(`FTX_SLOT_COUNT)-1:0]  slot_t;     // ring position
    typedef logic [$clog2(`FTX_SEG_BYTES)-1:0]   seg_idx_t;  // data byte index
    typedef logic [$clog2(`FTX_SEG_BYTES+1)-1:0] seg_sel_t;  // 0 = addr, 1..16 = data

    typedef enum logic [2:0] {
        IDLE, WAIT_SLOT, START, ADDR, DATA, STOP, CSUM_HI, CSUM_LO
    } frame_state_e;

    typedef enum logic [7:0] {
        NONE   = 8'h00,  // plain D0.0
        BEACON = 8'h7E,  // beacon code
        COMMA  = 8'hBC   // K28.5
    } event_code_e;

    typedef enum logic [7:0] {
        CODE_START = 8'h5C,  // K28.2
        CODE_STOP  = 8'h3C   // K28.1
    } ctrl_code_e;

endpackage

`default_nettype wire

// ==== hdl/ftx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ftx_top (
    input  wire logic          tx_clk,
    input  wire logic          rst_n_i,
    input  wire logic          ready_i,     // transceiver tx ready
    input  wire logic          seg_wr_i,    // segment byte write
    input  ftx_pkg::seg_idx_t  seg_idx_i,
    input  ftx_pkg::byte_t     seg_data_i,
    input  ftx_pkg::byte_t     seg_num_i,   // segment address of next frame
    input  wire logic          send_i,      // send one frame
    output ftx_pkg::word_t     tx_data_o,   // symbol word to the serializer
    output ftx_pkg::kflags_t   tx_is_k_o,
    output logic               busy_o
);

    ftx_pkg::slot_t slot;
    ftx_pkg::byte_t frame_byte;
    logic           frame_is_k;

    seg_rd_if seg_rd ();

    slot_counter slot_counter_i (
        .tx_clk  (tx_clk),
        .rst_n_i (rst_n_i),
        .ready_i (ready_i),
        .slot_o  (slot)
    );

    frame_sequencer frame_sequencer_i (
        .tx_clk       (tx_clk),
        .rst_n_i      (rst_n_i),
        .ready_i      (ready_i),
        .send_i       (send_i),
        .slot_i       (slot),
        .rd           (seg_rd.sequencer),
        .frame_byte_o (frame_byte),
        .frame_is_k_o (frame_is_k),
        .busy_o       (busy_o)
    );

    segment_store segment_store_i (
        .tx_clk     (tx_clk),
        .rst_n_i    (rst_n_i),
        .seg_wr_i   (seg_wr_i),
        .seg_idx_i  (seg_idx_i),
        .seg_data_i (seg_data_i),
        .seg_num_i  (seg_num_i),
        .rd         (seg_rd.store)
    );

    lane_mux lane_mux_i (
        .tx_clk       (tx_clk),
        .rst_n_i      (rst_n_i),
        .ready_i      (ready_i),
        .slot_i       (slot),
        .frame_byte_i (frame_byte),
        .frame_is_k_i (frame_is_k),
        .tx_data_o    (tx_data_o),
        .tx_is_k_o    (tx_is_k_o)
    );

endmodule

`default_nettype wire

// ==== hdl/lane_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ftx_config.svh"

module lane_mux (
    input  wire logic          tx_clk,
    input  wire logic          rst_n_i,
    input  wire logic          ready_i,       // link up
    input  ftx_pkg::slot_t     slot_i,        // current slot
    input  ftx_pkg::byte_t     frame_byte_i,  // data lane byte
    input  wire logic          frame_is_k_i,  // data lane K flag
    output ftx_pkg::word_t     tx_data_o,     // {data, event}
    output ftx_pkg::kflags_t   tx_is_k_o      // {data k, event k}
);

    ftx_pkg::event_code_e ev_code;  // event lane for this slot
    logic                 comma_slot;
    logic                 beacon_slot;

    assign comma_slot  = (slot_i % `FTX_COMMA_PERIOD) == 0;
    assign beacon_slot = (slot_i % `FTX_BEACON_PERIOD) == 0;

    always_comb begin
        if (comma_slot) begin
            ev_code = ftx_pkg::COMMA;   // comma wins over beacon
        end else if (beacon_slot) begin
            ev_code = ftx_pkg::BEACON;
        end else begin
            ev_code = ftx_pkg::NONE;
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_data_o <= '0;
            tx_is_k_o <= '0;
        end else if (!ready_i) begin
            tx_data_o <= '0;  // quiet lane while down
            tx_is_k_o <= '0;
        end else begin
            tx_data_o <= {frame_byte_i, ftx_pkg::byte_t'(ev_code)};
            tx_is_k_o <= {frame_is_k_i, ev_code == ftx_pkg::COMMA};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/seg_rd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface seg_rd_if;

    logic                lock;     // frame pending or on the wire
    logic                acc;      // add rd_byte into checksum
    ftx_pkg::seg_sel_t   rd_sel;   // 0 addr, 1..16 data bytes
    ftx_pkg::byte_t      rd_byte;  // selected byte
    ftx_pkg::csum_t      csum;     // 16'hFFFF minus running sum

    modport sequencer (
        output lock,
        output acc,
        output rd_sel,
        input  rd_byte,
        input  csum
    );

    modport store (
        input  lock,
        input  acc,
        input  rd_sel,
        output rd_byte,
        output csum
    );

endinterface

`default_nettype wire

// ==== hdl/segment_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ftx_config.svh"

module segment_store (
    input  wire logic            tx_clk,
    input  wire logic            rst_n_i,
    input  wire logic            seg_wr_i,    // byte write strobe
    input  ftx_pkg::seg_idx_t    seg_idx_i,   // byte index
    input  ftx_pkg::byte_t       seg_data_i,  // byte value
    input  ftx_pkg::byte_t       seg_num_i,   // segment address
    seg_rd_if.store              rd           // sequencer side
);

    ftx_pkg::byte_t seg_mem [`FTX_SEG_BYTES];  // segment payload
    ftx_pkg::byte_t seg_addr_q;                // address for this frame
    ftx_pkg::csum_t sum_q;                     // running byte sum
    logic           lock_q;
    logic           lock_rise;                 // frame just accepted

    assign lock_rise = rd.lock && !lock_q;

    always_ff @(posedge tx_clk) begin
        if (seg_wr_i && !rd.lock) begin
            seg_mem[seg_idx_i] <= seg_data_i;  // frozen while a frame is out
        end
        if (lock_rise) begin
            seg_addr_q <= seg_num_i;
        end
    end

    always_ff @(posedge tx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
            sum_q  <= '0;
        end else begin
            lock_q <= rd.lock;
            if (lock_rise) begin
                sum_q <= '0;                                    // fresh frame
            end else if (rd.acc) begin
                sum_q <= sum_q + ftx_pkg::csum_t'(rd.rd_byte);  // 16 bit wrap
            end
        end
    end

    // sel 0 is the address, data bytes follow
    assign rd.rd_byte = (rd.rd_sel == '0) ? seg_addr_q
                      : seg_mem[ftx_pkg::seg_idx_t'(rd.rd_sel - ftx_pkg::seg_sel_t'(1))];
    assign rd.csum    = 16'hFFFF - sum_q;

    // accumulation only inside a locked frame
    a_acc_locked : assert property (@(posedge tx_clk) disable iff (!rst_n_i)
        rd.acc |-> rd.lock && lock_q);

endmodule

`default_nettype wire

// ==== hdl/slot_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ftx_config.svh"

module slot_counter (
    input  wire logic          tx_clk,
    input  wire logic          rst_n_i,
    input  wire logic          ready_i,   // link up
    output ftx_pkg::slot_t     slot_o     // current symbol slot
);

    logic last_slot;  // end of ring

    assign last_slot = (slot_o == ftx_pkg::slot_t'(`FTX_SLOT_COUNT - 1));

    always_ff @(posedge tx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_o <= '0;
        end else if (!ready_i) begin
            slot_o <= '0;                        // park on slot 0 until ready
        end else if (last_slot) begin
            slot_o <= '0;                        // wrap
        end else begin
            slot_o <= slot_o + ftx_pkg::slot_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verif/frame_golden.hex ====
// columns: segment address, data bytes 0 to 15, checksum (16'hFFFF minus byte sum)
// frames: 0 ramp, 1 busy test, 2 aborted, 3 sent after the abort
01 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF F806
2A 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 FF4D
80 FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF EF8F
C3 DE AD BE EF 5C 3C BC 7E 00 00 A5 5A 12 34 56 78 F81F

// ==== verif/ftx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ftx_config.svh"

module ftx_tb;

    localparam int FRAMES   = 4;    // records in frame_golden.hex
    localparam int REC      = 18;   // addr, 16 data bytes, checksum
    localparam int WAIT_MAX = 500;  // cycles before a wait gives up

    logic              tx_clk = 1'b0;
    logic              rst_n_i;
    logic              ready_i;
    logic              seg_wr_i;
    ftx_pkg::seg_idx_t seg_idx_i;
    ftx_pkg::byte_t    seg_data_i;
    ftx_pkg::byte_t    seg_num_i;
    logic              send_i;
    ftx_pkg::word_t    tx_data_o;
    ftx_pkg::kflags_t  tx_is_k_o;
    logic              busy_o;

    logic [15:0] golden [FRAMES*REC];  // flat records, one per frame
    int          slot_n;               // parser slot, 0 at the locked comma
    integer      seed = 32'ha53f4184;

    ftx_top dut_i (.*);

    always #50 tx_clk = ~tx_clk;  // 100 ns period

    // event lane code a ring slot should carry
    function automatic ftx_pkg::byte_t event_byte(input int slot);
        if (slot % `FTX_COMMA_PERIOD == 0) return 8'hBC;  // K28.5
        if (slot % `FTX_BEACON_PERIOD == 0) return 8'h7E;
        return 8'h00;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input ftx_pkg::word_t got, input ftx_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0d ns: %s word %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_flags(input ftx_pkg::kflags_t got, input ftx_pkg::kflags_t exp,
                               input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0d ns: %s K flags %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_csum(input ftx_pkg::csum_t got, input ftx_pkg::csum_t exp,
                              input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0d ns: %s checksum %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0d ns: %s is %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    // file checksum against 16'hFFFF minus the byte sum
    task automatic check_golden(input int f);
        ftx_pkg::csum_t sum = '0;
        for (int i = 0; i < 17; i++) sum = sum + ftx_pkg::csum_t'(golden[f*REC+i][7:0]);
        check_csum(golden[f*REC+17], 16'hFFFF - sum, $sformatf("golden record %0d", f));
    endtask

    // one sampled word against the slot's event code and a data byte
    task automatic expect_word(input ftx_pkg::byte_t data, input logic data_k);
        ftx_pkg::byte_t ev;
        ev = event_byte(slot_n);
        check_word(tx_data_o, {data, ev}, $sformatf("slot %0d", slot_n));
        check_flags(tx_is_k_o, {data_k, ev == 8'hBC}, $sformatf("slot %0d", slot_n));
        slot_n = (slot_n + 1) % `FTX_SLOT_COUNT;
    endtask

    task automatic quiet_words(input int n);
        repeat (n) begin
            @(negedge tx_clk);
            check_word(tx_data_o, '0, "link down");
            check_flags(tx_is_k_o, '0, "link down");
            check_level(busy_o, 1'b0, "busy with link down");
        end
    endtask

    task automatic idle_words(input int n);
        repeat (n) begin
            @(negedge tx_clk);
            expect_word(8'h00, 1'b0);  // data lane silent between frames
            check_level(busy_o, 1'b0, "busy while idle");
        end
    endtask

    // raise ready and lock the parser on the first comma
    task automatic link_up();
        int n = 0;
        @(posedge tx_clk);
        ready_i <= 1'b1;
        do begin
            @(negedge tx_clk);
            n++;
            if (n > WAIT_MAX) stop_on_error("timeout: no comma after ready rose");
        end while (!(tx_is_k_o[0] && tx_data_o[7:0] == 8'hBC));
        slot_n = 0;
        expect_word(8'h00, 1'b0);
    endtask

    task automatic drop_link();
        @(posedge tx_clk);
        ready_i <= 1'b0;
        repeat (2) @(negedge tx_clk);  // one word of latency, then quiet
        check_word(tx_data_o, '0, "after abort");
        check_flags(tx_is_k_o, '0, "after abort");
        check_level(busy_o, 1'b0, "busy after abort");
    endtask

    task automatic send_frame(input int f);
        for (int i = 0; i < 16; i++) begin
            @(posedge tx_clk);
            seg_wr_i   <= 1'b1;
            seg_idx_i  <= ftx_pkg::seg_idx_t'(i);
            seg_data_i <= golden[f*REC+1+i][7:0];
        end
        @(posedge tx_clk);
        seg_wr_i  <= 1'b0;
        seg_num_i <= golden[f*REC][7:0];
        send_i    <= 1'b1;
        @(posedge tx_clk);
        send_i <= 1'b0;
    endtask

    // send and write attempts while a frame is pending
    task automatic stray_requests(input int f);
        int n = 0;
        while (!busy_o) begin
            @(negedge tx_clk);
            n++;
            if (n > WAIT_MAX) stop_on_error("timeout: busy never rose after send");
        end
        @(posedge tx_clk);
        send_i     <= 1'b1;
        seg_wr_i   <= 1'b1;
        seg_idx_i  <= '0;
        seg_data_i <= ~golden[f*REC+1][7:0];  // would corrupt data byte 0
        @(posedge tx_clk);
        send_i   <= 1'b0;
        seg_wr_i <= 1'b0;
    endtask

    // parse one frame off the data lane, optionally cut after some words
    task automatic receive_frame(input int f, input int cut);
        ftx_pkg::byte_t seq [21];  // odd-slot bytes in wire order
        int n = 0;
        int b = 0;
        seq[0] = 8'h5C;  // K28.2
        for (int i = 0; i < 17; i++) seq[i+1] = golden[f*REC+i][7:0];
        seq[18] = 8'h3C;  // K28.1
        seq[19] = golden[f*REC+17][15:8];
        seq[20] = golden[f*REC+17][7:0];
        @(negedge tx_clk);
        while (!tx_is_k_o[1]) begin  // hunt for the start code
            expect_word(8'h00, 1'b0);
            n++;
            if (n > WAIT_MAX) stop_on_error("timeout: frame start code never arrived");
            @(negedge tx_clk);
        end
        n = 0;
        while (b < 21) begin
            if (slot_n % 2 == 1) begin
                expect_word(seq[b], b == 0 || b == 18);
                check_level(busy_o, b < 20, "busy in frame");  // low with checksum low byte
                b++;
            end else begin
                expect_word(8'h00, 1'b0);  // distributed bus slot
                check_level(busy_o, 1'b1, "busy in frame");
            end
            n++;
            if (n == cut) begin
                drop_link();
                return;
            end
            if (b < 21) @(negedge tx_clk);
        end
    endtask

    initial begin
        int cut;
        rst_n_i    <= 1'b0;
        ready_i    <= 1'b0;
        seg_wr_i   <= 1'b0;
        seg_idx_i  <= '0;
        seg_data_i <= '0;
        seg_num_i  <= '0;
        send_i     <= 1'b0;
        slot_n     = 0;
        $readmemh("verif/frame_golden.hex", golden);
        for (int f = 0; f < FRAMES; f++) check_golden(f);
        repeat (10) @(posedge tx_clk);
        rst_n_i <= 1'b1;
        quiet_words(8);  // ready still low
        link_up();
        idle_words(2 * `FTX_SLOT_COUNT);  // whole ring cadence
        fork
            send_frame(0);
            receive_frame(0, 0);
        join
        idle_words(8);
        fork
            send_frame(1);
            receive_frame(1, 0);
            stray_requests(1);
        join
        idle_words(2 * `FTX_SLOT_COUNT);  // no second frame
        cut = 5 + ($unsigned($random(seed)) % 24);  // abort point inside the frame
        fork
            send_frame(2);
            receive_frame(2, cut);
        join
        quiet_words(4);
        link_up();
        fork
            send_frame(3);
            receive_frame(3, 0);
        join
        idle_words(8);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
